// ==== verilog.f ====
+incdir+include
verilog/soc_config_pkg.sv
verilog/soc_bus_pkg.sv
verilog/bus_decoder.sv
verilog/rom.sv
verilog/uart.sv
verilog/clint.sv
verilog/soc.sv
verif/soc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds and runs the SoC bus fabric testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module soc_tb -o Vsoc_tb

status=0
./obj_dir/Vsoc_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "ERRORS FOUND" sim.log || [ "$status" -ne 0 ]; then
  echo "simulation failed"
  exit 1
fi

echo "simulation passed"

// ==== verif/soc_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc_tb;

  `include "rom_image.svh"

  // four times about 80 accesses of up to 4 cycles plus 6 frames of 80 cycles
  localparam int timeout_cycles = 6000;
  localparam logic [31:0] lfsr_taps = 32'h8020_0003;

  logic clock;
  logic reset;
  soc_bus_pkg::mem_req_t request;
  soc_bus_pkg::mem_rsp_t response;
  logic tx;
  logic msip;
  logic mtip;

  logic [31:0] lfsr_state = 32'h83a14ab6;
  logic msip_model;
  logic [63:0] mtimecmp_model;
  logic uart_busy_model;
  logic [7:0] expected_bytes[$];
  int frames_received = 0;
  int cycle_count = 0;

  soc uut (
    .clock (clock),
    .reset (reset),
    .request (request),
    .response (response),
    .tx (tx),
    .msip (msip),
    .mtip (mtip)
  );

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  function automatic logic [31:0] galois_lfsr(input logic [31:0] state);
    logic lsb;
    lsb = state[0];
    state = state >> 1;
    if (lsb) begin
      state = state ^ lfsr_taps;
    end
    return state;
  endfunction

  // one lfsr step for every bit taken
  function logic [31:0] draw_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = galois_lfsr(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
    return value;
  endfunction

  function automatic soc_bus_pkg::periph_sel_t region_of(input logic [31:0] addr);
    if (addr >= soc_config_pkg::clint_base_addr && addr < soc_config_pkg::clint_top_addr) begin
      return soc_bus_pkg::sel_clint;
    end else if (addr >= soc_config_pkg::uart_base_addr &&
                 addr < soc_config_pkg::uart_top_addr) begin
      return soc_bus_pkg::sel_uart;
    end else if (addr < soc_config_pkg::rom_top_addr) begin
      return soc_bus_pkg::sel_rom;
    end
    return soc_bus_pkg::sel_none;
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                              input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] word;
    word = old_word;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        word[i*8 +: 8] = data[i*8 +: 8];
      end
    end
    return word;
  endfunction

  function automatic soc_bus_pkg::mem_rsp_t expected_read(input logic [31:0] addr);
    soc_bus_pkg::mem_rsp_t rsp;
    logic [31:0] offset;
    rsp = '0;
    rsp.ready = 1'b1;
    case (region_of(addr))
      soc_bus_pkg::sel_clint: begin
        offset = addr - soc_config_pkg::clint_base_addr;
        if (offset == soc_config_pkg::clint_msip_offset) begin
          rsp.rdata = {31'b0, msip_model};
        end else if (offset == soc_config_pkg::clint_mtimecmp_offset) begin
          rsp.rdata = mtimecmp_model[31:0];
        end else if (offset == soc_config_pkg::clint_mtimecmp_offset + 32'd4) begin
          rsp.rdata = mtimecmp_model[63:32];
        end
      end
      soc_bus_pkg::sel_uart: begin
        offset = addr - soc_config_pkg::uart_base_addr;
        if (offset == soc_config_pkg::uart_status_offset) begin
          rsp.rdata = {31'b0, uart_busy_model};
        end
      end
      soc_bus_pkg::sel_rom: rsp.rdata = rom_word(addr[5:2]);
      default: rsp.error = 1'b1;
    endcase
    return rsp;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("ERRORS FOUND");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_rsp(input string name, input soc_bus_pkg::mem_rsp_t got,
                           input soc_bus_pkg::mem_rsp_t exp);
    if (got.rdata !== exp.rdata || got.error !== exp.error) begin
      abort_run($sformatf("CHECK FAILED %s: rdata %h error %h, expected rdata %h error %h",
                          name, got.rdata, got.error, exp.rdata, exp.error));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  // valid is held until ready is seen, then dropped on that same edge
  task automatic bus_access(input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] wstrb, output soc_bus_pkg::mem_rsp_t rsp);
    soc_bus_pkg::mem_req_t req;
    req.valid = 1'b1;
    req.instr = 1'b0;
    req.addr = addr;
    req.wdata = wdata;
    req.wstrb = wstrb;
    @(posedge clock);
    request <= req;
    @(negedge clock);
    while (response.ready !== 1'b1) begin
      @(negedge clock);
    end
    rsp = response;
    @(posedge clock);
    request <= '0;
  endtask

  task automatic read_check(input logic [31:0] addr, input string name);
    soc_bus_pkg::mem_rsp_t rsp;
    bus_access(addr, 32'h0, 4'b0000, rsp);
    check_rsp(name, rsp, expected_read(addr));
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] strb);
    soc_bus_pkg::mem_rsp_t rsp;
    bus_access(addr, data, strb, rsp);
    check_bit("response.error on write", rsp.error, 1'b0);
  endtask

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      abort_run($sformatf("timeout after %0d cycles, the bus or the UART got stuck",
                          cycle_count));
    end
  end

  // tx is sampled in the middle of each bit
  initial begin : tx_monitor
    logic [7:0] data;
    logic [7:0] exp;
    wait (reset == 1'b1);
    forever begin
      @(negedge tx);
      repeat (soc_config_pkg::uart_divisor / 2) @(negedge clock);
      check_bit("tx start bit", tx, 1'b0);
      for (int b = 0; b < 8; b++) begin
        repeat (soc_config_pkg::uart_divisor) @(negedge clock);
        data[b] = tx;
      end
      repeat (soc_config_pkg::uart_divisor) @(negedge clock);
      check_bit("tx stop bit", tx, 1'b1);
      if (expected_bytes.size() == 0) begin
        abort_run("a UART frame appeared on tx with no byte written");
      end else begin
        exp = expected_bytes.pop_front();
        check_byte("tx byte", data, exp);
        frames_received = frames_received + 1;
      end
    end
  end

  initial begin : stimulus
    logic [31:0] addr;
    logic [31:0] data;
    logic [3:0] strb;
    logic [7:0] byte_a;
    logic [7:0] byte_b;
    int seen;
    reset = 1'b0;
    request = '0;
    msip_model = 1'b0;
    mtimecmp_model = '1;
    uart_busy_model = 1'b0;
    repeat (5) @(posedge clock);
    reset <= 1'b1;
    @(negedge clock);
    check_bit("tx after reset", tx, 1'b1);
    check_bit("msip after reset", msip, 1'b0);
    check_bit("mtip after reset", mtip, 1'b0);

    for (int i = 0; i < soc_config_pkg::rom_depth; i++) begin
      read_check(soc_config_pkg::rom_base_addr + 32'(i * 4), $sformatf("rom word %0d", i));
    end

    for (int n = 0; n < 8; n++) begin
      addr = draw_bits(32);
      while (region_of(addr) != soc_bus_pkg::sel_none) begin
        addr = draw_bits(32);
      end
      read_check(addr, $sformatf("unmapped read at %h", addr));
    end
    read_check(soc_config_pkg::rom_top_addr - 32'd4, "last rom word");
    read_check(soc_config_pkg::rom_top_addr, "first address above rom");

    addr = soc_config_pkg::clint_base_addr + soc_config_pkg::clint_msip_offset;
    write_word(addr, 32'h1, 4'b0001);
    msip_model = 1'b1;
    check_bit("msip", msip, 1'b1);
    read_check(addr, "msip register");
    write_word(addr, 32'h0, 4'b0001);
    msip_model = 1'b0;
    check_bit("msip", msip, 1'b0);
    read_check(addr, "msip register");

    addr = soc_config_pkg::clint_base_addr + soc_config_pkg::clint_mtimecmp_offset;
    for (int k = 0; k < 4; k++) begin
      data = draw_bits(32);
      strb = 4'(draw_bits(4));
      if (strb == 4'b0000) begin
        strb = 4'b1001;
      end
      write_word(addr + 32'((k % 2) * 4), data, strb);
      if (k % 2 == 0) begin
        mtimecmp_model[31:0] = merge_lanes(mtimecmp_model[31:0], data, strb);
      end else begin
        mtimecmp_model[63:32] = merge_lanes(mtimecmp_model[63:32], data, strb);
      end
      read_check(addr, "mtimecmp low word");
      read_check(addr + 32'd4, "mtimecmp high word");
    end
    write_word(addr, 32'h0, 4'b1111);
    write_word(addr + 32'd4, 32'h0, 4'b1111);
    mtimecmp_model = '0;
    read_check(addr, "mtimecmp low word");
    check_bit("mtip", mtip, 1'b1);
    write_word(addr, 32'hffff_ffff, 4'b1111);
    write_word(addr + 32'd4, 32'hffff_ffff, 4'b1111);
    mtimecmp_model = '1;
    read_check(addr + 32'd4, "mtimecmp high word");
    check_bit("mtip", mtip, 1'b0);

    // the second write of each pair has to wait for the first frame
    for (int pair = 0; pair < 3; pair++) begin
      byte_a = 8'(draw_bits(8));
      byte_b = 8'(draw_bits(8));
      expected_bytes.push_back(byte_a);
      write_word(soc_config_pkg::uart_base_addr + soc_config_pkg::uart_data_offset,
                 {24'b0, byte_a}, 4'b0001);
      uart_busy_model = 1'b1;
      read_check(soc_config_pkg::uart_base_addr + soc_config_pkg::uart_status_offset,
                 "uart status while sending");
      seen = frames_received;
      expected_bytes.push_back(byte_b);
      write_word(soc_config_pkg::uart_base_addr + soc_config_pkg::uart_data_offset,
                 {24'b0, byte_b}, 4'b0001);
      check_bit("frame finished before second write", frames_received == seen + 1, 1'b1);
    end
    while (expected_bytes.size() != 0) begin
      @(negedge clock);
    end
    repeat (soc_config_pkg::uart_divisor) @(posedge clock);
    uart_busy_model = 1'b0;
    read_check(soc_config_pkg::uart_base_addr + soc_config_pkg::uart_status_offset,
               "uart status after frames");
    read_check(soc_config_pkg::uart_base_addr + soc_config_pkg::uart_data_offset,
               "uart data register read");

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog/soc.sv ====
`timescale 1ns/10ps
`default_nettype none

module soc (
  input  logic clock,
  input  logic reset,
  input  soc_bus_pkg::mem_req_t request,
  output soc_bus_pkg::mem_rsp_t response,
  output logic tx,
  output logic msip,
  output logic mtip
);

  soc_bus_pkg::mem_req_t rom_request;
  soc_bus_pkg::mem_req_t uart_request;
  soc_bus_pkg::mem_req_t clint_request;
  soc_bus_pkg::mem_rsp_t rom_response;
  soc_bus_pkg::mem_rsp_t uart_response;
  soc_bus_pkg::mem_rsp_t clint_response;

  bus_decoder bus_decoder_comp (
    .clock (clock),
    .reset (reset),
    .request (request),
    .response (response),
    .rom_request (rom_request),
    .uart_request (uart_request),
    .clint_request (clint_request),
    .rom_response (rom_response),
    .uart_response (uart_response),
    .clint_response (clint_response)
  );

  rom rom_comp (
    .clock (clock),
    .reset (reset),
    .rom_request (rom_request),
    .rom_response (rom_response)
  );

  uart uart_comp (
    .clock (clock),
    .reset (reset),
    .uart_request (uart_request),
    .uart_response (uart_response),
    .tx (tx)
  );

  // msip and mtip would feed the CPU interrupt inputs
  clint clint_comp (
    .clock (clock),
    .reset (reset),
    .clint_request (clint_request),
    .clint_response (clint_response),
    .msip (msip),
    .mtip (mtip)
  );

endmodule

`default_nettype wire

// ==== verilog/clint.sv ====
`timescale 1ns/10ps
`default_nettype none

module clint (
  input  logic clock,
  input  logic reset,
  input  soc_bus_pkg::mem_req_t clint_request,
  output soc_bus_pkg::mem_rsp_t clint_response,
  output logic msip,
  output logic mtip
);

  logic msip_q;
  logic mtip_q;
  logic [63:0] mtime;
  logic [63:0] mtimecmp;
  logic ready_q;
  logic [31:0] rdata_q;
  logic [31:0] read_word;

  logic accept;
  logic is_write;

  assign accept = clint_request.valid && !ready_q;
  assign is_write = clint_request.wstrb != 4'b0000;

  always_comb begin
    case (clint_request.addr)
      soc_config_pkg::clint_msip_offset: read_word = {31'b0, msip_q};
      soc_config_pkg::clint_mtimecmp_offset: read_word = mtimecmp[31:0];
      soc_config_pkg::clint_mtimecmp_offset + 32'd4: read_word = mtimecmp[63:32];
      soc_config_pkg::clint_mtime_offset: read_word = mtime[31:0];
      soc_config_pkg::clint_mtime_offset + 32'd4: read_word = mtime[63:32];
      default: read_word = '0;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      msip_q <= 1'b0;
      mtip_q <= 1'b0;
      mtime <= '0;
      mtimecmp <= '1;
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
      mtime <= mtime + 64'd1;
      mtip_q <= mtime >= mtimecmp;
      if (accept && is_write) begin
        if (clint_request.addr == soc_config_pkg::clint_msip_offset &&
            clint_request.wstrb[0]) begin
          msip_q <= clint_request.wdata[0];
        end
        // mtimecmp takes only the byte lanes that are strobed
        for (int i = 0; i < 4; i++) begin
          if (clint_request.wstrb[i]) begin
            if (clint_request.addr == soc_config_pkg::clint_mtimecmp_offset) begin
              mtimecmp[i*8 +: 8] <= clint_request.wdata[i*8 +: 8];
            end
            if (clint_request.addr == soc_config_pkg::clint_mtimecmp_offset + 32'd4) begin
              mtimecmp[32 + i*8 +: 8] <= clint_request.wdata[i*8 +: 8];
            end
          end
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      rdata_q <= read_word;
    end
  end

  assign msip = msip_q;
  assign mtip = mtip_q;
  assign clint_response.rdata = rdata_q;
  assign clint_response.error = 1'b0;
  assign clint_response.ready = ready_q;

  a_ready_pulse: assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    ready_q |=> !ready_q
  );

endmodule

`default_nettype wire

// ==== verilog/uart.sv ====
`timescale 1ns/10ps
`default_nettype none

module uart (
  input  logic clock,
  input  logic reset,
  input  soc_bus_pkg::mem_req_t uart_request,
  output soc_bus_pkg::mem_rsp_t uart_response,
  output logic tx
);

  soc_bus_pkg::uart_state_t state;
  logic [15:0] div_count;
  logic [2:0] bit_count;
  logic [7:0] shift_q;
  logic tx_q;
  logic ready_q;
  logic [31:0] rdata_q;

  logic accept;
  logic is_write;
  logic data_write;
  logic status_read;
  logic busy;
  logic respond;
  logic bit_end;

  assign accept = uart_request.valid && !ready_q;
  assign is_write = uart_request.wstrb != 4'b0000;
  assign data_write = is_write && uart_request.addr == soc_config_pkg::uart_data_offset;
  assign status_read = !is_write && uart_request.addr == soc_config_pkg::uart_status_offset;
  assign busy = state != soc_bus_pkg::uart_idle;

  // a data write waits here until the previous frame has gone out
  assign respond = accept && !(data_write && busy);

  assign bit_end = div_count == 16'(soc_config_pkg::uart_divisor - 1);

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      state <= soc_bus_pkg::uart_idle;
      div_count <= '0;
      bit_count <= '0;
      tx_q <= 1'b1;
      ready_q <= 1'b0;
    end else begin
      ready_q <= respond;
      case (state)
        soc_bus_pkg::uart_idle: begin
          if (respond && data_write) begin
            tx_q <= 1'b0;
            div_count <= '0;
            state <= soc_bus_pkg::uart_start;
          end
        end
        soc_bus_pkg::uart_start: begin
          if (bit_end) begin
            div_count <= '0;
            bit_count <= '0;
            tx_q <= shift_q[0];
            state <= soc_bus_pkg::uart_data;
          end else begin
            div_count <= div_count + 16'd1;
          end
        end
        soc_bus_pkg::uart_data: begin
          if (bit_end) begin
            div_count <= '0;
            if (bit_count == 3'd7) begin
              tx_q <= 1'b1;
              state <= soc_bus_pkg::uart_stop;
            end else begin
              tx_q <= shift_q[0];
              bit_count <= bit_count + 3'd1;
            end
          end else begin
            div_count <= div_count + 16'd1;
          end
        end
        default: begin
          if (bit_end) begin
            div_count <= '0;
            state <= soc_bus_pkg::uart_idle;
          end else begin
            div_count <= div_count + 16'd1;
          end
        end
      endcase
    end
  end

  // bits leave lsb first so the register shifts right as each one goes
  always_ff @(posedge clock) begin
    if (state == soc_bus_pkg::uart_idle && respond && data_write) begin
      shift_q <= uart_request.wdata[7:0];
    end else if (bit_end && (state == soc_bus_pkg::uart_start ||
                             state == soc_bus_pkg::uart_data)) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  always_ff @(posedge clock) begin
    if (respond) begin
      rdata_q <= status_read ? {31'b0, busy} : '0;
    end
  end

  assign tx = tx_q;
  assign uart_response.rdata = rdata_q;
  assign uart_response.error = 1'b0;
  assign uart_response.ready = ready_q;

  a_idle_line_high: assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    state == soc_bus_pkg::uart_idle |-> tx
  );

endmodule

`default_nettype wire

// ==== verilog/rom.sv ====
`timescale 1ns/10ps
`default_nettype none

module rom (
  input  logic clock,
  input  logic reset,
  input  soc_bus_pkg::mem_req_t rom_request,
  output soc_bus_pkg::mem_rsp_t rom_response
);

  `include "rom_image.svh"

  logic accept;
  logic ready_q;
  logic [31:0] rdata_q;
  logic [$clog2(soc_config_pkg::rom_depth)-1:0] index;

  // word index within the sixteen-word image
  assign index = rom_request.addr[$clog2(soc_config_pkg::rom_depth)+1:2];

  // a raised ready means the current valid is the one just answered
  assign accept = rom_request.valid && !ready_q;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= accept;
    end
  end

  // writes get the same word back as a read
  always_ff @(posedge clock) begin
    if (accept) begin
      rdata_q <= rom_word(index);
    end
  end

  assign rom_response.rdata = rdata_q;
  assign rom_response.error = 1'b0;
  assign rom_response.ready = ready_q;

endmodule

`default_nettype wire

// ==== verilog/bus_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module bus_decoder (
  input  logic clock,
  input  logic reset,
  input  soc_bus_pkg::mem_req_t request,
  output soc_bus_pkg::mem_rsp_t response,
  output soc_bus_pkg::mem_req_t rom_request,
  output soc_bus_pkg::mem_req_t uart_request,
  output soc_bus_pkg::mem_req_t clint_request,
  input  soc_bus_pkg::mem_rsp_t rom_response,
  input  soc_bus_pkg::mem_rsp_t uart_response,
  input  soc_bus_pkg::mem_rsp_t clint_response
);

  soc_bus_pkg::periph_sel_t sel;
  logic [31:0] base_addr;
  logic [31:0] local_addr;
  logic unmapped;
  logic err_ready;

  // clint and uart are checked first and the rom takes everything below its top
  always_comb begin
    sel = soc_bus_pkg::sel_none;
    base_addr = '0;
    if (request.addr >= soc_config_pkg::clint_base_addr &&
        request.addr < soc_config_pkg::clint_top_addr) begin
      sel = soc_bus_pkg::sel_clint;
      base_addr = soc_config_pkg::clint_base_addr;
    end else if (request.addr >= soc_config_pkg::uart_base_addr &&
                 request.addr < soc_config_pkg::uart_top_addr) begin
      sel = soc_bus_pkg::sel_uart;
      base_addr = soc_config_pkg::uart_base_addr;
    end else if (request.addr < soc_config_pkg::rom_top_addr) begin
      sel = soc_bus_pkg::sel_rom;
      base_addr = soc_config_pkg::rom_base_addr;
    end
  end

  assign local_addr = request.addr - base_addr;

  always_comb begin
    rom_request = request;
    uart_request = request;
    clint_request = request;

    rom_request.addr = local_addr;
    uart_request.addr = local_addr;
    clint_request.addr = local_addr;

    rom_request.valid = request.valid && sel == soc_bus_pkg::sel_rom;
    uart_request.valid = request.valid && sel == soc_bus_pkg::sel_uart;
    clint_request.valid = request.valid && sel == soc_bus_pkg::sel_clint;
  end

  // the trailing valid cycle must not raise a second error pulse
  assign unmapped = request.valid && sel == soc_bus_pkg::sel_none && !err_ready;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      err_ready <= 1'b0;
    end else begin
      err_ready <= unmapped;
    end
  end

  // only one source can answer at a time so the order just fixes the mux
  always_comb begin
    if (rom_response.ready) begin
      response = rom_response;
    end else if (uart_response.ready) begin
      response = uart_response;
    end else if (clint_response.ready) begin
      response = clint_response;
    end else if (err_ready) begin
      response.rdata = '0;
      response.error = 1'b1;
      response.ready = 1'b1;
    end else begin
      response = '0;
    end
  end

  a_one_target: assert property (
    @(posedge clock) disable iff (reset == 1'b0)
    $onehot0({rom_request.valid, uart_request.valid, clint_request.valid})
  );

endmodule

`default_nettype wire

// ==== verilog/soc_bus_pkg.sv ====
`default_nettype none

package soc_bus_pkg;

  // a wstrb of zero marks a read
  typedef struct packed {
    logic valid;
    logic instr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0] wstrb;
  } mem_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic error;
    logic ready;
  } mem_rsp_t;

  typedef enum logic [1:0] {
    sel_none,
    sel_rom,
    sel_uart,
    sel_clint
  } periph_sel_t;

  typedef enum logic [1:0] {
    uart_idle,
    uart_start,
    uart_data,
    uart_stop
  } uart_state_t;

endpackage

`default_nettype wire

// ==== verilog/soc_config_pkg.sv ====
`default_nettype none

package soc_config_pkg;

  // top addresses of the fabric's address map are exclusive
  localparam logic [31:0] rom_base_addr = 32'h0000_0000;
  localparam logic [31:0] rom_top_addr = 32'h0000_0040;

  localparam logic [31:0] clint_base_addr = 32'h0200_0000;
  localparam logic [31:0] clint_top_addr = 32'h0200_C000;

  localparam logic [31:0] uart_base_addr = 32'h1000_0000;
  localparam logic [31:0] uart_top_addr = 32'h1000_0010;

  localparam int rom_depth = 16;

  // clocks per serial bit
  localparam int uart_divisor = 8;

  // register offsets relative to the region base
  localparam logic [31:0] clint_msip_offset = 32'h0000_0000;
  localparam logic [31:0] clint_mtimecmp_offset = 32'h0000_4000;
  localparam logic [31:0] clint_mtime_offset = 32'h0000_BFF8;

  localparam logic [31:0] uart_data_offset = 32'h0000_0000;
  localparam logic [31:0] uart_status_offset = 32'h0000_0004;

endpackage

`default_nettype wire

// ==== include/rom_image.svh ====
// the boot program prints two characters, parks mtimecmp at all ones and then waits
function automatic logic [31:0] rom_word(input logic [3:0] index);
  case (index)
    4'd0: rom_word = 32'h100000b7;
    4'd1: rom_word = 32'h04800113;
    4'd2: rom_word = 32'h0020a023;
    4'd3: rom_word = 32'h06900113;
    4'd4: rom_word = 32'h0020a023;
    4'd5: rom_word = 32'h020041b7;
    4'd6: rom_word = 32'hfff00213;
    4'd7: rom_word = 32'h0041a023;
    4'd8: rom_word = 32'h0041a223;
    4'd9: rom_word = 32'h10500073;
    4'd10: rom_word = 32'h0000006f;
    default: rom_word = 32'h00000013;
  endcase
endfunction
